//--- tempdisp_defs.svh
`ifndef TEMPDISP_DEFS_SVH
`define TEMPDISP_DEFS_SVH

// Reading and font code widths
`define VALUE_W         16
`define CODE_W          8

// Width of one decimal digit and of the digit counter
`define DIGIT_W         4
`define DIGIT_IDX_W     3

// Five digits cover 0 to 65535, plus two unit codes
`define NUM_DIGITS      5
`define NUM_CODES       7

// Font code of '0', digit d maps to FONT_ZERO + d
`define FONT_ZERO       16

// x / 10 == (x * 52429) >> 19 for every 16-bit x
`define RECIP_TEN       52429
`define RECIP_SHIFT     19

// Unit suffix, letter C and the degree mark
`define UNIT_HI         35
`define UNIT_LO         2

`endif

//--- tempdisp_pkg.sv
`default_nettype none

`include "tempdisp_defs.svh"

package tempdisp_pkg;

    // Raw sensor reading
    typedef logic [`VALUE_W-1:0] value_t;

    // One character index into the font memory
    typedef logic [`CODE_W-1:0] font_code_t;

    // Digit position, 0 is the least significant digit
    typedef logic [`DIGIT_IDX_W-1:0] digit_idx_t;

    // Slot 0 is the leftmost character on screen
    typedef logic [`NUM_CODES-1:0][`CODE_W-1:0] display_t;

    // Conversion sequencer
    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        STEP,
        STORE
    } conv_state_t;

endpackage

`default_nettype wire

//--- convert_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "tempdisp_defs.svh"

module convert_control (
    input  wire                       clk,
    input  wire                       reset,
    input  wire tempdisp_pkg::value_t reading,
    output logic                      load,
    output logic                      divide,
    output logic                      step,
    output logic                      commit,
    output tempdisp_pkg::digit_idx_t  digit_idx
);

    tempdisp_pkg::conv_state_t state;
    tempdisp_pkg::value_t      last_value;
    logic                      changed;
    logic                      last_digit;

    // Only start a conversion when the reading moves away from the last one taken
    assign changed    = (reading != last_value);
    assign last_digit = (digit_idx == tempdisp_pkg::digit_idx_t'(`NUM_DIGITS - 1));

    // One strobe per state, load only while idle
    assign load   = (state == tempdisp_pkg::IDLE) && changed;
    assign divide = (state == tempdisp_pkg::DIVIDE);
    assign step   = (state == tempdisp_pkg::STEP);
    assign commit = (state == tempdisp_pkg::STORE);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= tempdisp_pkg::IDLE;
            last_value <= '0;
            digit_idx  <= '0;
        end else begin
            case (state)
                tempdisp_pkg::IDLE: begin
                    if (changed) begin
                        last_value <= reading;
                        digit_idx  <= '0;
                        state      <= tempdisp_pkg::DIVIDE;
                    end
                end
                tempdisp_pkg::DIVIDE: begin
                    state <= tempdisp_pkg::STEP;
                end
                tempdisp_pkg::STEP: begin
                    // Counter wraps so it is back at zero for the next reading
                    if (last_digit) begin
                        digit_idx <= '0;
                        state     <= tempdisp_pkg::STORE;
                    end else begin
                        digit_idx <= digit_idx + 1'b1;
                        state     <= tempdisp_pkg::DIVIDE;
                    end
                end
                tempdisp_pkg::STORE: begin
                    state <= tempdisp_pkg::IDLE;
                end
                default: begin
                    state <= tempdisp_pkg::IDLE;
                end
            endcase
        end
    end

    // Downstream slot selection relies on the counter never reaching NUM_DIGITS
    a_digit_idx_range: assert property (
        @(posedge clk) disable iff (!reset)
        digit_idx < tempdisp_pkg::digit_idx_t'(`NUM_DIGITS)
    );

    // Datapath and result stage assume strobes never overlap
    a_single_strobe: assert property (
        @(posedge clk) disable iff (!reset)
        $onehot0({load, divide, step, commit})
    );

endmodule

`default_nettype wire

//--- divide_by_ten.sv
`timescale 1ns/10ps
`default_nettype none

`include "tempdisp_defs.svh"

module divide_by_ten (
    input  wire                       clk,
    input  wire                       reset,
    input  wire tempdisp_pkg::value_t reading,
    input  wire                       load,
    input  wire                       divide,
    input  wire                       step,
    output logic [`DIGIT_W-1:0]       remainder
);

    localparam int PRODUCT_W = 2 * `VALUE_W;

    typedef logic [PRODUCT_W-1:0] product_t;

    localparam tempdisp_pkg::value_t RECIP = `RECIP_TEN;
    localparam tempdisp_pkg::value_t TEN   = 10;

    tempdisp_pkg::value_t working;
    product_t             product;
    tempdisp_pkg::value_t quotient;
    tempdisp_pkg::value_t diff;

    // Working value, replaced by its own quotient after every digit
    always_ff @(posedge clk) begin
        if (!reset) begin
            working <= '0;
        end else if (load) begin
            working <= reading;
        end else if (step) begin
            working <= quotient;
        end
    end

    // Registered reciprocal product, maps onto a single DSP multiply
    always_ff @(posedge clk) begin
        if (divide) begin
            product <= product_t'(working) * product_t'(RECIP);
        end
    end

    assign quotient = tempdisp_pkg::value_t'(product >> `RECIP_SHIFT);

    // x mod 10 = x - 10 * (x / 10)
    assign diff      = working - quotient * TEN;
    assign remainder = diff[`DIGIT_W-1:0];

    // Checks the reciprocal against the working value produced by the previous step
    a_remainder_digit: assert property (
        @(posedge clk) disable iff (!reset)
        step |-> (diff < TEN)
    );

endmodule

`default_nettype wire

//--- digit_collect.sv
`timescale 1ns/10ps
`default_nettype none

`include "tempdisp_defs.svh"

module digit_collect (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           step,
    input  wire                           commit,
    input  wire tempdisp_pkg::digit_idx_t digit_idx,
    input  wire [`DIGIT_W-1:0]            remainder,
    output tempdisp_pkg::display_t        display_codes,
    output logic                          done
);

    localparam tempdisp_pkg::font_code_t ZERO_CODE    = `FONT_ZERO;
    localparam tempdisp_pkg::font_code_t UNIT_HI_CODE = `UNIT_HI;
    localparam tempdisp_pkg::font_code_t UNIT_LO_CODE = `UNIT_LO;

    // Display for a reading of 0, units in the two top slots
    localparam tempdisp_pkg::display_t RESET_DISPLAY = {
        UNIT_HI_CODE,
        UNIT_LO_CODE,
        {`NUM_DIGITS{ZERO_CODE}}
    };

    tempdisp_pkg::font_code_t [`NUM_DIGITS-1:0] staging;
    tempdisp_pkg::font_code_t                   code;
    tempdisp_pkg::digit_idx_t                   slot;

    // Remainder is always a decimal digit, so no letter offset
    assign code = ZERO_CODE + tempdisp_pkg::font_code_t'(remainder);

    // Digits arrive least significant first, text is drawn left to right
    assign slot = tempdisp_pkg::digit_idx_t'(`NUM_DIGITS - 1) - digit_idx;

    always_ff @(posedge clk) begin
        if (step) begin
            staging[slot] <= code;
        end
    end

    // Display only changes once all five digits are in place
    always_ff @(posedge clk) begin
        if (!reset) begin
            display_codes <= RESET_DISPLAY;
            done          <= 1'b0;
        end else begin
            done <= commit;
            if (commit) begin
                display_codes <= {UNIT_HI_CODE, UNIT_LO_CODE, staging};
            end
        end
    end

    // Back-to-back commits would mean the sequencer skipped its digit loop
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!reset)
        done |=> !done
    );

endmodule

`default_nettype wire

//--- hex_to_decimal.sv
`timescale 1ns/10ps
`default_nettype none

`include "tempdisp_defs.svh"

module hex_to_decimal (
    input  wire                       clk,
    input  wire                       reset,
    input  wire tempdisp_pkg::value_t reading,
    output tempdisp_pkg::display_t    display_codes,
    output logic                      done
);

    logic                     load;
    logic                     divide;
    logic                     step;
    logic                     commit;
    tempdisp_pkg::digit_idx_t digit_idx;
    logic [`DIGIT_W-1:0]      remainder;

    // Change detection and digit loop sequencing
    convert_control convert_control_i (
        .clk       (clk),
        .reset     (reset),
        .reading   (reading),
        .load      (load),
        .divide    (divide),
        .step      (step),
        .commit    (commit),
        .digit_idx (digit_idx)
    );

    divide_by_ten divide_by_ten_i (
        .clk       (clk),
        .reset     (reset),
        .reading   (reading),
        .load      (load),
        .divide    (divide),
        .step      (step),
        .remainder (remainder)
    );

    // Font codes and the committed display word
    digit_collect digit_collect_i (
        .clk           (clk),
        .reset         (reset),
        .step          (step),
        .commit        (commit),
        .digit_idx     (digit_idx),
        .remainder     (remainder),
        .display_codes (display_codes),
        .done          (done)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    // Free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- tb_hex_to_decimal.sv
`timescale 1ns/10ps
`default_nettype none

`include "tempdisp_defs.svh"

module tb_hex_to_decimal;

    localparam int NUM_RANDOM   = 200;
    localparam int DONE_LIMIT   = 40;
    localparam int QUIET_CYCLES = 30;

    logic                   clk;
    logic                   reset;
    tempdisp_pkg::value_t   reading;
    tempdisp_pkg::display_t display_codes;
    logic                   done;

    integer               seed;
    int                   errors;
    int                   tests_run;
    int                   tests_failed;
    int                   test_errors;
    int                   done_count;
    int                   target;
    int                   edges;
    logic                 seen_done;
    logic [31:0]          raw;
    tempdisp_pkg::value_t current;
    tempdisp_pkg::value_t base;
    tempdisp_pkg::value_t checked;
    tempdisp_pkg::value_t expected_q[$];
    tempdisp_pkg::value_t boundary[6] = '{16'd1, 16'd9, 16'd10, 16'd65535, 16'd10000, 16'd16389};

    tb_clock_gen clock_gen_i (.clk(clk));

    hex_to_decimal hex_to_decimal_i (
        .clk           (clk),
        .reset         (reset),
        .reading       (reading),
        .display_codes (display_codes),
        .done          (done)
    );

    // Decimal digits most significant first, then degree mark and letter C
    function automatic tempdisp_pkg::display_t expected_display(input tempdisp_pkg::value_t v);
        tempdisp_pkg::display_t codes;
        int rest;
        rest = int'(v);
        for (int pos = `NUM_DIGITS - 1; pos >= 0; pos--) begin
            codes[pos] = tempdisp_pkg::font_code_t'(`FONT_ZERO + rest % 10);
            rest = rest / 10;
        end
        codes[`NUM_DIGITS]     = tempdisp_pkg::font_code_t'(`UNIT_LO);
        codes[`NUM_DIGITS + 1] = tempdisp_pkg::font_code_t'(`UNIT_HI);
        return codes;
    endfunction

    function automatic tempdisp_pkg::value_t differ_from(input tempdisp_pkg::value_t v,
                                                         input tempdisp_pkg::value_t avoid);
        return (v == avoid) ? v + 16'd1 : v;
    endfunction

    // Each done must show the oldest reading still waiting for its conversion
    always @(negedge clk) begin
        if (reset && done) begin
            assert (expected_q.size() != 0) else begin
                $display("Unexpected done at %0t with no conversion pending", $time);
                errors = errors + 1;
            end
            if (expected_q.size() != 0) begin
                checked = expected_q.pop_front();
                assert (display_codes == expected_display(checked)) else begin
                    $display("[ERROR] %0t: reading %0d shows %h, expected %h", $time,
                             checked, display_codes, expected_display(checked));
                    errors = errors + 1;
                end
            end
            done_count = done_count + 1;
        end
    end

    task automatic apply_reading(input tempdisp_pkg::value_t v);
        @(posedge clk);
        reading <= v;
        expected_q.push_back(v);
        current = v;
    endtask

    task automatic wait_for_done(input int count);
        int cycles;
        cycles = 0;
        while (done_count < count && cycles < DONE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        assert (done_count >= count) else begin
            $display("Timeout: no done within %0d cycles at %0t", DONE_LIMIT, $time);
            errors = errors + 1;
        end
    endtask

    task automatic watch_quiet();
        seen_done = 1'b0;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (done) begin
                seen_done = 1'b1;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed", tests_run, name);
        end
        test_errors = errors;
    endtask

    initial begin
        seed         = 79238;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        done_count   = 0;
        current      = '0;
        reset   <= 1'b0;
        reading <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b1;

        watch_quiet();
        assert (!seen_done) else begin
            $display("done pulsed although the reading stayed at 0");
            errors++;
        end
        assert (display_codes == expected_display(16'd0)) else begin
            $display("[ERROR] %0t: reset display %h, expected %h", $time,
                     display_codes, expected_display(16'd0));
            errors++;
        end
        finish_test("reset display");

        // Digit rollovers, full scale and a value that needs the exact reciprocal
        foreach (boundary[i]) begin
            apply_reading(boundary[i]);
            wait_for_done(done_count + 1);
        end
        finish_test("boundary readings");

        for (int n = 0; n < NUM_RANDOM; n++) begin
            raw = $random(seed);
            apply_reading(differ_from(raw[15:0], current));
            wait_for_done(done_count + 1);
        end
        finish_test("random readings");

        apply_reading(differ_from(16'd4321, current));
        target    = done_count + 1;
        edges     = 0;
        seen_done = 1'b0;
        while (!seen_done && edges < DONE_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            seen_done = done;
        end
        assert (seen_done && edges == 12) else begin
            $display("[ERROR] %0t: done after %0d edges, expected 12", $time, edges);
            errors++;
        end
        wait_for_done(target);
        finish_test("latency");

        // Two changes land mid conversion and only the final one is converted next
        target = done_count;
        base   = differ_from(16'd12345, current);
        apply_reading(base);
        repeat (3) @(posedge clk);
        reading <= base ^ 16'hff00;
        repeat (3) @(posedge clk);
        apply_reading(base ^ 16'h00ff);
        wait_for_done(target + 1);
        wait_for_done(target + 2);
        finish_test("change during conversion");

        // Reading wanders off mid conversion and returns to the value being converted
        target = done_count;
        base   = differ_from(16'd2468, current);
        apply_reading(base);
        repeat (3) @(posedge clk);
        reading <= base ^ 16'h0f0f;
        repeat (3) @(posedge clk);
        reading <= base;
        wait_for_done(target + 1);
        watch_quiet();
        assert (!seen_done && done_count == target + 1) else begin
            $display("done pulsed after re-applying the displayed reading");
            errors++;
        end
        assert (display_codes == expected_display(current)) else begin
            $display("[ERROR] %0t: display %h, expected %h", $time,
                     display_codes, expected_display(current));
            errors++;
        end
        finish_test("repeated reading");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
tempdisp_pkg.sv
convert_control.sv
divide_by_ten.sv
digit_collect.sv
hex_to_decimal.sv
tb_clock_gen.sv
tb_hex_to_decimal.sv

//--- Makefile
TOP = tb_hex_to_decimal

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

obj_dir/V$(TOP): verilog.f *.sv tempdisp_defs.svh
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
